// File: Makefile
# Verilator build and run for rv_lite.

VERILATOR ?= verilator
TOP       ?= tb_rv_lite
FILELIST  ?= rv_lite.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: rv_lite.f
src/rv_pkg.sv
src/rv_exec_if.sv
src/rv_result_if.sv
src/rv_regs.sv
src/rv_fetch_decode.sv
src/rv_execute.sv
src/rv_result.sv
src/rv_lite_top.sv
tb/tb_rv_lite.sv

// File: src/rv_exec_if.sv
`timescale 1ns/1ns

interface rv_exec_if;
    import rv_pkg::*;

    logic     valid;
    logic     illegal;
    alu_op_t  alu_op;
    reg_idx_t rd;
    logic     reg_write;
    logic     store;
    word_t    op1;          // Forwarded rs1.
    word_t    op2;          // Forwarded rs2 or immediate.
    word_t    store_data;
    word_t    store_offset;

    modport decode (
        output valid,
        output illegal,
        output alu_op,
        output rd,
        output reg_write,
        output store,
        output op1,
        output op2,
        output store_data,
        output store_offset
    );

    modport execute (
        input valid,
        input illegal,
        input alu_op,
        input rd,
        input reg_write,
        input store,
        input op1,
        input op2,
        input store_data,
        input store_offset
    );

endinterface

// File: src/rv_execute.sv
`timescale 1ns/1ns

module rv_execute
(
    rv_exec_if.execute  ex,
    rv_result_if.execute res
);
    import rv_pkg::*;

    logic [4:0] shamt;
    word_t      alu_result;
    word_t      store_addr;

    assign shamt = ex.op2[4:0];

    always_comb
    begin
        case (ex.alu_op)
            ALU_ADD:
                alu_result = ex.op1 + ex.op2;
            ALU_SUB:
                alu_result = ex.op1 - ex.op2;
            ALU_SLL:
                alu_result = ex.op1 << shamt;
            ALU_SLT:
                alu_result = {{(XLEN-1){1'b0}}, $signed(ex.op1) < $signed(ex.op2)};
            ALU_SLTU:
                alu_result = {{(XLEN-1){1'b0}}, ex.op1 < ex.op2};
            ALU_XOR:
                alu_result = ex.op1 ^ ex.op2;
            ALU_SRL:
                alu_result = ex.op1 >> shamt;
            ALU_SRA:
                alu_result = word_t'($signed(ex.op1) >>> shamt);
            ALU_OR:
                alu_result = ex.op1 | ex.op2;
            ALU_AND:
                alu_result = ex.op1 & ex.op2;
            ALU_PASS2:
                alu_result = ex.op2; // LUI.
            default:
                alu_result = '0;
        endcase
    end

    // Store address uses base plus S-type offset.
    assign store_addr = ex.op1 + ex.store_offset;

    assign res.valid      = ex.valid;
    assign res.illegal    = ex.illegal;
    assign res.rd         = ex.rd;
    assign res.reg_write  = ex.reg_write;
    assign res.store      = ex.store;
    assign res.value      = ex.store ? store_addr : alu_result;
    assign res.store_data = ex.store_data;

endmodule

// File: src/rv_fetch_decode.sv
`timescale 1ns/1ns

module rv_fetch_decode
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    output logic             o_instr_req,
    output rv_pkg::word_t    o_instr_addr,
    input  logic             i_instr_ack,
    input  rv_pkg::word_t    i_instr_data,
    rv_exec_if.decode        ex,
    rv_result_if.bypass      fwd,
    input  logic             i_wb_we,
    input  rv_pkg::reg_idx_t i_wb_rd,
    input  rv_pkg::word_t    i_wb_data
);
    import rv_pkg::*;

    logic       accept;
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    word_t      rf_data1;
    word_t      rf_data2;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_u;
    logic       alt;
    logic       d_illegal;
    logic       d_reg_write;
    logic       d_store;
    alu_op_t    d_alu_op;
    word_t      d_op2;

    // Priority is execute, then retire, then the register file.
    function automatic word_t forward(input reg_idx_t rs, input word_t rf,
                                      input logic ex_we, input reg_idx_t ex_rd,
                                      input word_t ex_val, input logic wb_we,
                                      input reg_idx_t wb_rd, input word_t wb_val);
        if (rs == '0)
            return '0;
        else if (ex_we && (ex_rd == rs))
            return ex_val;
        else if (wb_we && (wb_rd == rs))
            return wb_val;
        else
            return rf;
    endfunction

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_instr_req  <= 1'b0;
            o_instr_addr <= RESET_ADDR;
        end
        else
        begin
            o_instr_req <= 1'b1;
            if (accept)
                o_instr_addr <= o_instr_addr + XLEN'(4);
        end
    end

    assign accept = o_instr_req && i_instr_ack;

    assign opcode = i_instr_data[6:0];
    assign rd     = i_instr_data[11:7];
    assign f3     = i_instr_data[14:12];
    assign rs1    = i_instr_data[19:15];
    assign rs2    = i_instr_data[24:20];
    assign f7     = i_instr_data[31:25];
    assign imm_i  = {{(XLEN-12){i_instr_data[31]}}, i_instr_data[31:20]};
    assign imm_s  = {{(XLEN-12){i_instr_data[31]}}, i_instr_data[31:25], i_instr_data[11:7]};
    assign imm_u  = {i_instr_data[31:12], 12'b0};

    rv_regs u_regs
    (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_rd     (i_wb_rd),
        .i_we     (i_wb_we),
        .i_wdata  (i_wb_data),
        .o_rdata1 (rf_data1),
        .o_rdata2 (rf_data2)
    );

    assign rs1_val = forward(rs1, rf_data1, fwd.reg_write, fwd.rd, fwd.value,
                             i_wb_we, i_wb_rd, i_wb_data);
    assign rs2_val = forward(rs2, rf_data2, fwd.reg_write, fwd.rd, fwd.value,
                             i_wb_we, i_wb_rd, i_wb_data);

    // Alternate funct7 only counts for SUB on register ops and SRA on both.
    assign alt = (f7 == F7_ALT) && ((opcode == OPC_OP) || (f3 == F3_SRL_SRA));

    always_comb
    begin
        d_illegal   = 1'b0;
        d_reg_write = 1'b0;
        d_store     = 1'b0;
        d_op2       = rs2_val;
        case (f3)
            F3_ADD_SUB: d_alu_op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     d_alu_op = ALU_SLL;
            F3_SLT:     d_alu_op = ALU_SLT;
            F3_SLTU:    d_alu_op = ALU_SLTU;
            F3_XOR:     d_alu_op = ALU_XOR;
            F3_SRL_SRA: d_alu_op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      d_alu_op = ALU_OR;
            default:    d_alu_op = ALU_AND;
        endcase
        case (opcode)
            OPC_OP:
            begin
                d_reg_write = 1'b1;
                d_illegal   = !((f7 == F7_BASE) || (alt && ((f3 == F3_ADD_SUB) ||
                                                            (f3 == F3_SRL_SRA))));
            end
            OPC_OP_IMM:
            begin
                d_reg_write = 1'b1;
                d_op2       = imm_i;
                if (f3 == F3_SLL)
                    d_illegal = (f7 != F7_BASE);
                else if (f3 == F3_SRL_SRA)
                    d_illegal = (f7 != F7_BASE) && !alt;
            end
            OPC_LUI:
            begin
                d_reg_write = 1'b1;
                d_alu_op    = ALU_PASS2;
                d_op2       = imm_u;
            end
            OPC_STORE:
            begin
                d_store   = 1'b1;
                d_illegal = (f3 != F3_SW);
            end
            default: d_illegal = 1'b1;
        endcase
        if (d_illegal)
        begin
            d_reg_write = 1'b0;
            d_store     = 1'b0;
        end
        d_reg_write = d_reg_write && (rd != '0); // x0 never written.
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            ex.valid     <= 1'b0;
            ex.illegal   <= 1'b0;
            ex.reg_write <= 1'b0;
            ex.store     <= 1'b0;
        end
        else
        begin
            ex.valid     <= accept;
            ex.illegal   <= accept && d_illegal;
            ex.reg_write <= accept && d_reg_write;
            ex.store     <= accept && d_store;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            ex.alu_op       <= d_alu_op;
            ex.rd           <= rd;
            ex.op1          <= rs1_val;
            ex.op2          <= d_op2;
            ex.store_data   <= rs2_val;
            ex.store_offset <= imm_s;
        end
    end

    // Write-back from the retire stage never targets x0.
    a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_wb_we |-> (i_wb_rd != '0));

endmodule

// File: src/rv_lite_top.sv
`timescale 1ns/1ns

module rv_lite_top
(
    input  logic          i_clk,
    input  logic          i_arst_n,
    output logic          o_instr_req,
    output rv_pkg::word_t o_instr_addr,
    input  logic          i_instr_ack,
    input  rv_pkg::word_t i_instr_data,
    output logic          o_data_req,
    output logic          o_data_write,
    output rv_pkg::word_t o_data_addr,
    output rv_pkg::word_t o_data_wdata,
    output logic          o_instr_issued,
    output logic          o_illegal_instr
);
    import rv_pkg::*;

    logic     wb_we;
    reg_idx_t wb_rd;
    word_t    wb_data;

    rv_exec_if   ex_if();
    rv_result_if res_if();

    rv_fetch_decode u_fetch_decode
    (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .o_instr_req  (o_instr_req),
        .o_instr_addr (o_instr_addr),
        .i_instr_ack  (i_instr_ack),
        .i_instr_data (i_instr_data),
        .ex           (ex_if.decode),
        .fwd          (res_if.bypass),
        .i_wb_we      (wb_we),
        .i_wb_rd      (wb_rd),
        .i_wb_data    (wb_data)
    );

    rv_execute u_execute
    (
        .ex  (ex_if.execute),
        .res (res_if.execute)
    );

    rv_result u_result
    (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .res             (res_if.result),
        .o_data_req      (o_data_req),
        .o_data_write    (o_data_write),
        .o_data_addr     (o_data_addr),
        .o_data_wdata    (o_data_wdata),
        .o_instr_issued  (o_instr_issued),
        .o_illegal_instr (o_illegal_instr),
        .o_wb_we         (wb_we),
        .o_wb_rd         (wb_rd),
        .o_wb_data       (wb_data)
    );

endmodule

// File: src/rv_pkg.sv
package rv_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    localparam word_t RESET_ADDR = '0; // First fetch address.

    // Major opcodes, bits [6:0].
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // Arithmetic funct3.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_SW      = 3'b010; // Word store only.

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB and SRA.

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASS2 = 4'd10 // LUI, result is op2.
    } alu_op_t;

endpackage

// File: src/rv_regs.sv
`timescale 1ns/1ns

module rv_regs
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  logic             i_we,
    input  rv_pkg::word_t    i_wdata,
    output rv_pkg::word_t    o_rdata1,
    output rv_pkg::word_t    o_rdata2
);
    import rv_pkg::*;

    word_t regs [1:31]; // No storage for x0.

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_we && (i_rd != '0))
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    always_comb
    begin
        o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
        o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];
    end

endmodule

// File: src/rv_result.sv
`timescale 1ns/1ns

module rv_result
(
    input  logic             i_clk,
    input  logic             i_arst_n,
    rv_result_if.result      res,
    output logic             o_data_req,
    output logic             o_data_write,
    output rv_pkg::word_t    o_data_addr,
    output rv_pkg::word_t    o_data_wdata,
    output logic             o_instr_issued,
    output logic             o_illegal_instr,
    output logic             o_wb_we,
    output rv_pkg::reg_idx_t o_wb_rd,
    output rv_pkg::word_t    o_wb_data
);
    import rv_pkg::*;

    logic     r_valid;
    logic     r_illegal;
    logic     r_store;
    logic     r_reg_write;
    reg_idx_t r_rd;
    word_t    r_value;
    word_t    r_store_data;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            r_valid     <= 1'b0;
            r_illegal   <= 1'b0;
            r_store     <= 1'b0;
            r_reg_write <= 1'b0;
            r_rd        <= '0;
        end
        else
        begin
            r_valid     <= res.valid;
            r_illegal   <= res.illegal;
            r_store     <= res.store;
            r_reg_write <= res.reg_write;
            r_rd        <= res.rd;
        end
    end

    always_ff @(posedge i_clk)
    begin
        r_value      <= res.value;
        r_store_data <= res.store_data;
    end

    assign o_data_req      = r_valid && r_store;
    assign o_data_write    = r_store; // Stores only.
    assign o_data_addr     = r_value;
    assign o_data_wdata    = r_store_data;
    assign o_instr_issued  = r_valid && !r_illegal;
    assign o_illegal_instr = r_valid && r_illegal;
    assign o_wb_we         = r_reg_write;
    assign o_wb_rd         = r_rd;
    assign o_wb_data       = r_value;

    // Decode must have dropped the store of any illegal word.
    a_store_not_illegal: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_data_req && o_illegal_instr));

    a_write_is_req: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_data_write == o_data_req);

endmodule

// File: src/rv_result_if.sv
`timescale 1ns/1ns

interface rv_result_if;
    import rv_pkg::*;

    logic     valid;
    logic     illegal;
    reg_idx_t rd;
    logic     reg_write;
    logic     store;
    word_t    value;      // ALU result or store address.
    word_t    store_data;

    modport execute (
        output valid,
        output illegal,
        output rd,
        output reg_write,
        output store,
        output value,
        output store_data
    );

    modport result (
        input valid,
        input illegal,
        input rd,
        input reg_write,
        input store,
        input value,
        input store_data
    );

    // Forwarding from the instruction in execute.
    modport bypass (
        input rd,
        input reg_write,
        input value
    );

endinterface

// File: tb/tb_rv_lite.sv
`timescale 1ns/1ns

module tb_rv_lite;
    import rv_pkg::*;

    logic  i_clk;
    logic  i_arst_n;
    logic  o_instr_req;
    word_t o_instr_addr;
    logic  i_instr_ack;
    word_t i_instr_data;
    logic  o_data_req;
    logic  o_data_write;
    word_t o_data_addr;
    word_t o_data_wdata;
    logic  o_instr_issued;
    logic  o_illegal_instr;

    word_t imem [0:255];
    word_t ref_regs [0:31];  // Reference register model.
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t rng_state        = 32'd36103;
    bit    gaps_on          = 1'b1;
    int    prog_len         = 0;
    int    accept_count     = 0;
    int    issued_seen      = 0;
    int    illegal_seen     = 0;
    int    legal_expected   = 0;
    int    illegal_expected = 0;

    rv_lite_top uut
    (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .o_instr_req     (o_instr_req),
        .o_instr_addr    (o_instr_addr),
        .i_instr_ack     (i_instr_ack),
        .i_instr_data    (i_instr_data),
        .o_data_req      (o_data_req),
        .o_data_write    (o_data_write),
        .o_data_addr     (o_data_addr),
        .o_data_wdata    (o_data_wdata),
        .o_instr_issued  (o_instr_issued),
        .o_illegal_instr (o_illegal_instr)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic check_equal(input word_t got, input word_t exp, input string msg);
        if (got !== exp)
            stop_with_failure($sformatf("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
                                        $time, msg, got, exp));
    endtask

    // 32-bit xorshift.
    function automatic word_t next_random();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input reg_idx_t rd, input reg_idx_t rs1,
                                         input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t itype_word(input logic [11:0] imm, input reg_idx_t rs1,
                                         input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t store_word(input logic [11:0] imm, input reg_idx_t rs2,
                                         input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    // RV32I arithmetic semantics where alt selects SUB and SRA.
    function automatic word_t expected_alu(input logic [2:0] f3, input logic alt,
                                           input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put_word(input word_t w);
        imem[prog_len[7:0]] = w;
        prog_len++;
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt, input reg_idx_t rd,
                          input reg_idx_t rs1, input reg_idx_t rs2);
        put_word(rtype_word(alt ? F7_ALT : F7_BASE, f3, rd, rs1, rs2));
        if (rd != '0)
            ref_regs[rd] = expected_alu(f3, alt, ref_regs[rs1], ref_regs[rs2]);
        legal_expected++;
    endtask

    task automatic imm_op(input logic [2:0] f3, input logic alt, input reg_idx_t rd,
                          input reg_idx_t rs1, input logic [11:0] imm);
        put_word(itype_word(imm, rs1, f3, rd));
        if (rd != '0)
            ref_regs[rd] = expected_alu(f3, alt, ref_regs[rs1], sext12(imm));
        legal_expected++;
    endtask

    task automatic lui_op(input reg_idx_t rd, input logic [19:0] imm);
        put_word({imm, rd, OPC_LUI});
        if (rd != '0)
            ref_regs[rd] = {imm, 12'h000};
        legal_expected++;
    endtask

    task automatic sw_op(input reg_idx_t rs2, input reg_idx_t rs1, input logic [11:0] off);
        put_word(store_word(off, rs2, rs1, F3_SW));
        exp_addr.push_back(ref_regs[rs1] + sext12(off));
        exp_data.push_back(ref_regs[rs2]);
        legal_expected++;
    endtask

    task automatic illegal_op(input word_t w);
        put_word(w);
        illegal_expected++;
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t v);
        word_t upper;
        upper = v + 32'h800; // Rounds for the signed low part.
        lui_op(rd, upper[31:12]);
        imm_op(F3_ADD_SUB, 1'b0, rd, rd, v[11:0]);
    endtask

    // Instruction memory answering after 0 to 3 cycles.
    initial
    begin
        int gap;
        gap          = 0;
        i_instr_ack  = 1'b0;
        i_instr_data = '0;
        forever
        begin
            @(posedge i_clk);
            #1;
            if (i_instr_ack)
                gap = gaps_on ? int'(next_random() & 32'h3) : 0;
            if (i_arst_n && o_instr_req && (int'(o_instr_addr[31:2]) < prog_len) &&
                (gap == 0))
            begin
                i_instr_ack  = 1'b1;
                i_instr_data = imem[o_instr_addr[9:2]];
            end
            else
            begin
                if (gap > 0)
                    gap--;
                i_instr_ack  = 1'b0;
                i_instr_data = 32'hffff_ffff; // Illegal if ever taken.
            end
        end
    end

    task automatic check_store();
        word_t a;
        word_t d;
        if (exp_addr.size() == 0)
            stop_with_failure("Store strobe seen while no store was expected.");
        else
        begin
            a = exp_addr.pop_front();
            d = exp_data.pop_front();
            check_equal(word_t'(o_data_write), 32'd1, "data write with request");
            check_equal(o_data_addr, a, "store address");
            check_equal(o_data_wdata, d, "store data");
        end
    endtask

    // Mid-cycle monitor of fetch, stores and retire strobes.
    initial
    begin
        forever
        begin
            @(negedge i_clk);
            if (i_arst_n)
            begin
                check_equal(o_instr_addr, word_t'(accept_count * 4), "fetch address");
                if (o_instr_req && i_instr_ack)
                    accept_count++;
                if (o_data_req)
                    check_store();
                if (o_instr_issued)
                    issued_seen++;
                if (o_illegal_instr)
                    illegal_seen++;
                check_equal(word_t'(o_instr_issued & o_illegal_instr), '0,
                            "issued and illegal together");
            end
        end
    end

    function automatic bit program_busy();
        return (accept_count < prog_len) || (exp_addr.size() != 0) ||
               (issued_seen + illegal_seen < legal_expected + illegal_expected);
    endfunction

    task automatic run_program(input string name);
        int cycles;
        cycles = 0;
        while (program_busy() && (cycles < 400))
        begin
            @(posedge i_clk);
            cycles++;
        end
        if (program_busy())
            stop_with_failure($sformatf("Timeout: program %s did not drain.", name));
        else
        begin
            repeat (3) @(posedge i_clk); // Catch stray strobes.
            check_equal(word_t'(issued_seen), word_t'(legal_expected),
                        $sformatf("%s issued count", name));
            check_equal(word_t'(illegal_seen), word_t'(illegal_expected),
                        $sformatf("%s illegal count", name));
        end
    endtask

    task automatic reset_and_fetch();
        imm_op(F3_ADD_SUB, 1'b0, 1, 0, 12'd42);
        sw_op(1, 0, 12'h010);
        repeat (10)
        begin
            @(negedge i_clk);
            check_equal(word_t'(o_instr_req), '0, "request during reset");
            check_equal(word_t'({o_data_req, o_instr_issued, o_illegal_instr}), '0,
                        "strobes during reset");
            check_equal(o_instr_addr, RESET_ADDR, "address during reset");
        end
        @(posedge i_clk);
        #1;
        i_arst_n = 1'b1;
        @(posedge i_clk);
        @(negedge i_clk);
        check_equal(word_t'(o_instr_req), 32'd1, "request after reset");
        run_program("reset");
    endtask

    task automatic imm_and_lui();
        imm_op(F3_ADD_SUB, 1'b0, 1, 0, 12'h123);
        imm_op(F3_ADD_SUB, 1'b0, 2, 0, 12'hffb);
        imm_op(F3_SLT, 1'b0, 3, 2, 12'h001);
        imm_op(F3_SLTU, 1'b0, 4, 2, 12'h001);
        imm_op(F3_XOR, 1'b0, 5, 1, 12'h0f0);
        imm_op(F3_OR, 1'b0, 6, 2, 12'h100);
        imm_op(F3_AND, 1'b0, 7, 1, 12'h0ff);
        imm_op(F3_SLL, 1'b0, 8, 1, 12'h007);
        imm_op(F3_SRL_SRA, 1'b0, 9, 2, 12'h004);
        imm_op(F3_SRL_SRA, 1'b1, 10, 2, {F7_ALT, 5'd2});
        lui_op(11, 20'habcde);
        imm_op(F3_SLTU, 1'b0, 12, 1, 12'hfff);
        for (int r = 1; r <= 12; r++)
            sw_op(reg_idx_t'(r), 0, 12'(r * 4));
        sw_op(2, 11, 12'h800); // Negative offset.
        run_program("immediate");
    endtask

    task automatic forwarding_chains();
        gaps_on = 1'b0;
        imm_op(F3_ADD_SUB, 1'b0, 1, 0, 12'd5);
        imm_op(F3_ADD_SUB, 1'b0, 1, 1, 12'd7);
        sw_op(1, 0, 12'h000);
        imm_op(F3_ADD_SUB, 1'b0, 2, 0, 12'd100);
        imm_op(F3_ADD_SUB, 1'b0, 3, 0, 12'd3);
        reg_op(F3_ADD_SUB, 1'b0, 4, 2, 2);   // Two apart.
        sw_op(4, 2, 12'h008);
        imm_op(F3_ADD_SUB, 1'b0, 6, 0, 12'd1);
        imm_op(F3_ADD_SUB, 1'b0, 6, 0, 12'd2);
        sw_op(6, 0, 12'h00c);                // Newest x6 wins.
        reg_op(F3_ADD_SUB, 1'b0, 7, 6, 1);
        reg_op(F3_ADD_SUB, 1'b1, 8, 7, 6);
        sw_op(8, 7, 12'h000);
        run_program("forwarding");
        gaps_on = 1'b1;
    endtask

    task automatic reg_reg_ops();
        logic [2:0] f3;
        logic       alt;
        for (int k = 0; k < 10; k++)
        begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? F3_ADD_SUB : F3_SRL_SRA);
            alt = (k >= 8);
            load_const(10, next_random());
            load_const(11, next_random());
            load_const(12, next_random());
            reg_op(f3, alt, 13, 10, 11);
            sw_op(13, 12, 12'(next_random()));
        end
        run_program("register");
    endtask

    task automatic illegal_and_x0();
        imm_op(F3_ADD_SUB, 1'b0, 5, 0, 12'd77);
        imm_op(F3_ADD_SUB, 1'b0, 0, 0, 12'd123);
        lui_op(0, 20'h12345);
        sw_op(0, 0, 12'h010);
        illegal_op(rtype_word(7'b0000001, F3_ADD_SUB, 5, 5, 5));   // MUL.
        illegal_op({12'd0, 5'd0, 3'b010, 5'd5, 7'b0000011});       // LW.
        illegal_op(store_word(12'h014, 5, 0, 3'b000));             // SB.
        illegal_op(itype_word({F7_ALT, 5'd1}, 5, F3_SLL, 5));
        illegal_op(32'h0000_0073);                                 // ECALL.
        illegal_op(32'hffff_ffff);
        sw_op(5, 0, 12'h014);
        run_program("illegal");
    endtask

    initial
    begin
        i_arst_n = 1'b0;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = '0;
        reset_and_fetch();
        imm_and_lui();
        forwarding_chains();
        reg_reg_ops();
        illegal_and_x0();
        $display("STATUS: PASS");
        $finish;
    end

endmodule
